//--- src/vmul_pkg.sv
// Vector multiply lane types
package vmul_pkg;

  // one vector element or write-back word
  typedef logic [31:0] elem_t;
  // full product of two elements
  typedef logic [63:0] prod_t;
  // signed 16x16 partial product, 17-bit signed by 17-bit signed
  typedef logic signed [33:0] pp_t;

  // element width as decoded from vtype
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  // multiply flavour, plain or fused
  typedef enum logic [2:0] {
    MUL   = 3'd0,
    MACC  = 3'd1,
    NMSAC = 3'd2,
    MADD  = 3'd3,
    NMSUB = 3'd4
  } mul_op_t;

  // one element request from the decoder
  typedef struct packed {
    elem_t      vs1;
    elem_t      vs2;
    elem_t      vs3;
    sew_t       sew;
    mul_op_t    op;
    // bit 0 for vs1, bit 1 for vs2 and vs3
    logic [1:0] is_signed;
    logic       high;
    logic       widen;
  } mul_req_t;

  // control riding along the datapath
  typedef struct packed {
    sew_t    sew;
    mul_op_t op;
    logic    high;
    logic    widen;
    elem_t   addend;
  } mul_ctrl_t;

  // extended operands into the multiplier
  typedef struct packed {
    elem_t     a;
    elem_t     b;
    logic      a_signed;
    logic      b_signed;
    mul_ctrl_t ctrl;
  } mul_opnd_t;

  // registered partial products, middle of the multiplier
  typedef struct packed {
    pp_t       ll;
    pp_t       lh;
    pp_t       hl;
    pp_t       hh;
    mul_ctrl_t ctrl;
  } mul_part_t;

  // finished product with its control
  typedef struct packed {
    prod_t     p;
    mul_ctrl_t ctrl;
  } mul_prod_t;

endpackage

//--- src/vmul_operand_stage.sv
// Multiply lane operand stage
`timescale 1ns/100ps

module vmul_operand_stage import vmul_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      start,
  input  mul_req_t  req,
  output logic      opnd_valid,
  output mul_opnd_t opnd
);

  // extended element values
  elem_t     vs1_ext, vs2_ext, vs3_ext;
  // next register contents
  mul_opnd_t opnd_next;
  logic      swap;

  // widen the low SEW bits of an element to 32 bits
  function automatic elem_t extend(input elem_t v, input sew_t sew, input logic sgn);
    elem_t r;
    case (sew)
      SEW8:    r = {{24{sgn & v[7]}}, v[7:0]};
      SEW16:   r = {{16{sgn & v[15]}}, v[15:0]};
      // SEW32 and anything unexpected go through as is
      default: r = v;
    endcase
    return r;
  endfunction

  // vs1 follows bit 0, vs2 and vs3 share bit 1
  assign vs1_ext = extend(req.vs1, req.sew, req.is_signed[0]);
  assign vs2_ext = extend(req.vs2, req.sew, req.is_signed[1]);
  assign vs3_ext = extend(req.vs3, req.sew, req.is_signed[1]);

  // madd and nmsub multiply by the old vd and add vs2
  assign swap = (req.op == MADD) || (req.op == NMSUB);

  always_comb begin
    opnd_next.a           = vs1_ext;
    opnd_next.b           = swap ? vs3_ext : vs2_ext;
    opnd_next.a_signed    = req.is_signed[0];
    opnd_next.b_signed    = req.is_signed[1];
    opnd_next.ctrl.sew    = req.sew;
    opnd_next.ctrl.op     = req.op;
    opnd_next.ctrl.high   = req.high;
    opnd_next.ctrl.widen  = req.widen;
    // plain mul ignores it downstream
    opnd_next.ctrl.addend = swap ? vs2_ext : vs3_ext;
  end

  // stage 1 register
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      opnd_valid <= 1'b0;
      opnd       <= '0;
    end else begin
      opnd_valid <= start;
      opnd       <= opnd_next;
    end
  end

endmodule

//--- src/vmul_multiplier.sv
// Two-stage 32x32 multiplier
`timescale 1ns/100ps

module vmul_multiplier import vmul_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      opnd_valid,
  input  mul_opnd_t opnd,
  output logic      prod_valid,
  output mul_prod_t prod
);

  // 17-bit signed views of the operand halves
  logic [16:0] a_lo, a_hi, b_lo, b_hi;
  // stage A next value and register
  mul_part_t   part_next;
  mul_part_t   part;
  logic        part_valid;
  // stage B sum
  prod_t       ll_x, lh_x, hl_x, hh_x;
  prod_t       sum;

  // signed 17x17 multiply, exact in 34 bits
  function automatic pp_t pp_mul(input logic [16:0] x, input logic [16:0] y);
    pp_t r;
    r = $signed(x) * $signed(y);
    return r;
  endfunction

  // low halves are always unsigned
  assign a_lo = {1'b0, opnd.a[15:0]};
  assign b_lo = {1'b0, opnd.b[15:0]};
  // high halves carry the operand sign when signed
  assign a_hi = {opnd.a_signed & opnd.a[31], opnd.a[31:16]};
  assign b_hi = {opnd.b_signed & opnd.b[31], opnd.b[31:16]};

  always_comb begin
    part_next.ll   = pp_mul(a_lo, b_lo);
    // cross terms, weight 2^16
    part_next.lh   = pp_mul(a_lo, b_hi);
    part_next.hl   = pp_mul(a_hi, b_lo);
    // weight 2^32
    part_next.hh   = pp_mul(a_hi, b_hi);
    part_next.ctrl = opnd.ctrl;
  end

  // stage A register
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      part_valid <= 1'b0;
      part       <= '0;
    end else begin
      part_valid <= opnd_valid;
      part       <= part_next;
    end
  end

  // sign-extend each partial product to 64 bits
  assign ll_x = {{30{part.ll[33]}}, part.ll};
  assign lh_x = {{30{part.lh[33]}}, part.lh};
  assign hl_x = {{30{part.hl[33]}}, part.hl};
  assign hh_x = {{30{part.hh[33]}}, part.hh};

  // shifted sum, wraps mod 2^64 which is exact here
  always_comb begin
    sum = ll_x;
    sum = sum + (lh_x << 16);
    sum = sum + (hl_x << 16);
    sum = sum + (hh_x << 32);
  end

  // stage B register
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      prod_valid <= 1'b0;
      prod       <= '0;
    end else begin
      prod_valid <= part_valid;
      prod.p     <= sum;
      prod.ctrl  <= part.ctrl;
    end
  end

endmodule

//--- src/vmul_result_stage.sv
// Multiply lane result stage
`timescale 1ns/100ps

module vmul_result_stage import vmul_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      prod_valid,
  input  mul_prod_t prod,
  output logic      done,
  output elem_t     wdata
);

  // upper SEW slice of the product
  elem_t hi_slice;
  // mask for the result width
  elem_t mask;
  // plain mul result before masking
  elem_t mul_raw;
  // fused path
  elem_t term;
  elem_t fused_raw;
  elem_t result;
  logic  fused;
  logic  negate;

  // high half sits just above the SEW bits
  always_comb begin
    case (prod.ctrl.sew)
      SEW8:    hi_slice = {24'd0, prod.p[15:8]};
      SEW16:   hi_slice = {16'd0, prod.p[31:16]};
      default: hi_slice = prod.p[63:32];
    endcase
  end

  // SEW bits, or 2*SEW when widening
  always_comb begin
    case (prod.ctrl.sew)
      SEW8:    mask = prod.ctrl.widen ? 32'h0000_ffff : 32'h0000_00ff;
      SEW16:   mask = prod.ctrl.widen ? 32'hffff_ffff : 32'h0000_ffff;
      // SEW32 widen is capped at 32 bits
      default: mask = 32'hffff_ffff;
    endcase
  end

  // widen always takes the low bits
  assign mul_raw = (prod.ctrl.high && !prod.ctrl.widen) ? hi_slice : prod.p[31:0];

  assign fused  = (prod.ctrl.op != MUL);
  assign negate = (prod.ctrl.op == NMSAC) || (prod.ctrl.op == NMSUB);

  // only low bits matter, mask trims the wrap
  assign term      = negate ? (32'd0 - prod.p[31:0]) : prod.p[31:0];
  assign fused_raw = term + prod.ctrl.addend;

  // zero-extend to the 32-bit write-back word
  assign result = (fused ? fused_raw : mul_raw) & mask;

  // output register
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      done  <= 1'b0;
      wdata <= '0;
    end else begin
      done  <= prod_valid;
      wdata <= result;
    end
  end

endmodule

//--- src/vmul_lane.sv
// Vector lane multiply unit
`timescale 1ns/100ps

module vmul_lane import vmul_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     start,
  input  mul_req_t req,
  output logic     done,
  output elem_t    wdata
);

  // operand stage to multiplier
  logic      opnd_valid;
  mul_opnd_t opnd;
  // multiplier to result stage
  logic      prod_valid;
  mul_prod_t prod;

  // extension and operand swap
  vmul_operand_stage u_operand (
    .CLK        (CLK),
    .nRST       (nRST),
    .start      (start),
    .req        (req),
    .opnd_valid (opnd_valid),
    .opnd       (opnd)
  );

  // two register stages
  vmul_multiplier u_mult (
    .CLK        (CLK),
    .nRST       (nRST),
    .opnd_valid (opnd_valid),
    .opnd       (opnd),
    .prod_valid (prod_valid),
    .prod       (prod)
  );

  // slice, accumulate and register
  vmul_result_stage u_result (
    .CLK        (CLK),
    .nRST       (nRST),
    .prod_valid (prod_valid),
    .prod       (prod),
    .done       (done),
    .wdata      (wdata)
  );

endmodule

//--- sim/vmul_ref.svh
// Multiply lane reference model
`ifndef VMUL_REF_SVH
`define VMUL_REF_SVH

// element width in bits
function automatic int sew_width(input sew_t sew);
  case (sew)
    SEW8:    return 8;
    SEW16:   return 16;
    default: return 32;
  endcase
endfunction

// low n bits of v as a 64-bit two's complement value
function automatic logic [63:0] operand_value(input elem_t v, input int n, input logic sgn);
  logic [63:0] low;
  logic [63:0] x;
  low = (64'd1 << n) - 64'd1;
  x   = {32'd0, v} & low;
  // element sign bit fills everything above it
  if (sgn && v[n-1]) begin
    x = x | ~low;
  end
  return x;
endfunction

// expected write-back word for one request
function automatic elem_t expected_wdata(input mul_req_t r);
  int          n;
  int          w;
  logic        swap;
  logic [63:0] x1;
  logic [63:0] x2;
  logic [63:0] x3;
  logic [63:0] b;
  logic [63:0] add;
  logic [63:0] p;
  logic [63:0] res;
  n = sew_width(r.sew);
  // widening doubles the width, one word at most
  w = r.widen ? 2 * n : n;
  if (w > 32) begin
    w = 32;
  end
  x1 = operand_value(r.vs1, n, r.is_signed[0]);
  x2 = operand_value(r.vs2, n, r.is_signed[1]);
  x3 = operand_value(r.vs3, n, r.is_signed[1]);
  // madd and nmsub multiply by old vd, add vs2
  swap = (r.op == MADD) || (r.op == NMSUB);
  b    = swap ? x3 : x2;
  add  = swap ? x2 : x3;
  // low 64 bits of the exact product
  p = x1 * b;
  if (r.op == MUL) begin
    res = (r.high && !r.widen) ? (p >> n) : p;
  end else if ((r.op == NMSAC) || (r.op == NMSUB)) begin
    res = add - p;
  end else begin
    res = add + p;
  end
  res = res & ((64'd1 << w) - 64'd1);
  return res[31:0];
endfunction

`endif

//--- sim/vmul_lane_tb.sv
// Multiply lane testbench
`timescale 1ns/100ps

module vmul_lane_tb import vmul_pkg::*; ();

  // elements per test group
  localparam int n_corner = 3 * 16;
  localparam int n_high   = 3 * 3 * 8;
  localparam int n_widen  = 2 * 2 * 8;
  localparam int n_fused  = 4 * 3 * 8;
  localparam int n_stream = 300;
  localparam int n_elems  = n_corner + n_high + n_widen + n_fused + n_stream;
  // hard stop for the whole run
  localparam int cycle_limit = n_elems + 50;
  // start edge to the edge that sees done
  localparam int latency = 4;

  logic     CLK;
  logic     nRST;
  logic     start;
  mul_req_t req;
  logic     done;
  elem_t    wdata;

  integer      seed;
  // expected words and the cycle each one is due
  elem_t       exp_q[$];
  int unsigned due_q[$];
  int unsigned cyc = 0;

  `include "vmul_ref.svh"

  vmul_lane uut (
    .CLK   (CLK),
    .nRST  (nRST),
    .start (start),
    .req   (req),
    .done  (done),
    .wdata (wdata)
  );

  // 40 ns period
  always #20 CLK = ~CLK;

  function automatic elem_t rand_word();
    return $random(seed);
  endfunction

  function automatic elem_t sew_mask(input sew_t sew);
    case (sew)
      SEW8:    return 32'h0000_00ff;
      SEW16:   return 32'h0000_ffff;
      default: return 32'hffff_ffff;
    endcase
  endfunction

  // 0, all ones, most negative and 1 with junk above the element
  function automatic elem_t corner_value(input int idx, input sew_t sew);
    elem_t m;
    elem_t base;
    m = sew_mask(sew);
    case (idx)
      0:       base = 32'd0;
      1:       base = 32'hffff_ffff;
      2:       base = (m >> 1) + 32'd1;
      default: base = 32'd1;
    endcase
    return (base & m) | (rand_word() & ~m);
  endfunction

  function automatic mul_req_t random_req(input mul_op_t op, input sew_t sew,
                                          input logic [1:0] sgn, input logic high,
                                          input logic widen);
    mul_req_t r;
    r.vs1       = rand_word();
    r.vs2       = rand_word();
    r.vs3       = rand_word();
    r.sew       = sew;
    r.op        = op;
    r.is_signed = sgn;
    r.high      = high;
    r.widen     = widen;
    return r;
  endfunction

  task automatic report_failure(input string what);
    $display("Error at %0d ns: %s", $time, what);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input elem_t got, input elem_t want);
    if (got !== want) begin
      $display("Mismatch at %0d ns: %s = %h, expected %h", $time, name, got, want);
      $display("SIMULATION FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  // one element per call on the falling edge
  task automatic issue(input mul_req_t r);
    @(negedge CLK);
    start = 1'b1;
    req   = r;
    exp_q.push_back(expected_wdata(r));
  endtask

  // scoreboard sees values settled since the falling edge
  always @(posedge CLK) begin
    elem_t       want;
    int unsigned due;
    cyc = cyc + 1;
    if (cyc > cycle_limit) begin
      report_failure("timeout, the cycle limit was reached");
    end else if (!nRST) begin
      // nothing comes out during reset
      check_value("done", {31'd0, done}, 32'd0);
      check_value("wdata", wdata, 32'd0);
    end else begin
      if (start) begin
        due_q.push_back(cyc + latency);
      end
      if (done) begin
        if (due_q.size() == 0) begin
          report_failure("done pulsed with no element in flight");
        end else begin
          want = exp_q.pop_front();
          due  = due_q.pop_front();
          if (due != cyc) begin
            report_failure($sformatf("done came at cycle %0d, due at %0d", cyc, due));
          end else begin
            check_value("wdata", wdata, want);
          end
        end
      end else if ((due_q.size() != 0) && (due_q[0] <= cyc)) begin
        report_failure("done missing 4 cycles after start");
      end
    end
  end

  initial begin
    mul_req_t   r;
    elem_t      w;
    mul_op_t    op;
    logic [1:0] sgn;
    int         s;
    int         i;
    int         j;
    int         k;
    CLK   = 1'b0;
    nRST  = 1'b0;
    start = 1'b0;
    req   = '0;
    seed  = 32'hb0d9686e;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;

    // low-half mul on corner operands
    for (s = 0; s < 3; s++) begin
      for (i = 0; i < 4; i++) begin
        for (j = 0; j < 4; j++) begin
          r     = random_req(MUL, sew_t'(2'(s)), 2'b11, 1'b0, 1'b0);
          r.vs1 = corner_value(i, sew_t'(2'(s)));
          r.vs2 = corner_value(j, sew_t'(2'(s)));
          issue(r);
        end
      end
    end

    // vmulh, vmulhu, vmulhsu
    for (s = 0; s < 3; s++) begin
      for (k = 0; k < 3; k++) begin
        sgn = (k == 0) ? 2'b11 : ((k == 1) ? 2'b00 : 2'b10);
        for (i = 0; i < 8; i++) begin
          issue(random_req(MUL, sew_t'(2'(s)), sgn, 1'b1, 1'b0));
        end
      end
    end

    // widening, signed then unsigned
    for (s = 0; s < 2; s++) begin
      for (k = 0; k < 2; k++) begin
        sgn = (k == 0) ? 2'b11 : 2'b00;
        for (i = 0; i < 8; i++) begin
          issue(random_req(MUL, sew_t'(2'(s)), sgn, 1'b0, 1'b1));
        end
      end
    end

    // macc, nmsac, madd, nmsub
    for (k = 0; k < 4; k++) begin
      for (s = 0; s < 3; s++) begin
        for (i = 0; i < 8; i++) begin
          w  = rand_word();
          op = mul_op_t'(3'(k + 1));
          issue(random_req(op, sew_t'(2'(s)), w[1:0], 1'b0, 1'b0));
        end
      end
    end

    // back-to-back mix of everything
    for (i = 0; i < n_stream; i++) begin
      w  = rand_word();
      op = mul_op_t'(3'(w % 5));
      if (op == MUL) begin
        r = random_req(op, sew_t'(2'((w >> 8) % 3)), w[17:16], w[20], w[21]);
      end else begin
        r = random_req(op, sew_t'(2'((w >> 8) % 3)), w[17:16], 1'b0, 1'b0);
      end
      issue(r);
    end

    @(negedge CLK);
    start = 1'b0;
    req   = '0;
    // last result plus room for stray done pulses
    repeat (2 * latency) @(posedge CLK);
    if ((exp_q.size() == 0) && (due_q.size() == 0)) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("SIMULATION FAILED");
      $fatal(1, "elements were left without a result");
    end
  end

endmodule

//--- sim.f
+incdir+sim
src/vmul_pkg.sv
src/vmul_operand_stage.sv
src/vmul_multiplier.sv
src/vmul_result_stage.sv
src/vmul_lane.sv
sim/vmul_lane_tb.sv

//--- Makefile
TOP := vmul_lane_tb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): sim.f $(wildcard src/*.sv sim/*.sv sim/*.svh)
	verilator --binary --timing -Wno-fatal -j 0 --top-module $(TOP) -f sim.f

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir
